/* hdl/csr_defs.svh */
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

`define CSR_XLEN            32
`define CSR_ADDR_W          12

// user counter aliases
`define CSR_ADDR_CYCLE      12'hC00
`define CSR_ADDR_INSTRET    12'hC02
`define CSR_ADDR_CYCLEH     12'hC80
`define CSR_ADDR_INSTRETH   12'hC82

// machine mode
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MCOUNTEREN 12'h306
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MTVAL      12'h343
`define CSR_ADDR_MCYCLE     12'hB00
`define CSR_ADDR_MINSTRET   12'hB02
`define CSR_ADDR_MCYCLEH    12'hB80
`define CSR_ADDR_MINSTRETH  12'hB82

// rv32 with I, M, A and U
`define CSR_MISA_VALUE      32'h4010_1101

`endif

/* hdl/csr_pkg.sv */
`include "csr_defs.svh"

package csr_pkg;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_e;

    typedef enum logic [1:0] {
        MTVEC_DIRECT   = 2'd0,
        MTVEC_VECTORED = 2'd1
    } mtvec_mode_e;

    typedef enum logic [4:0] {
        EXC_ILLEGAL_INSTR = 5'd2,
        EXC_BREAKPOINT    = 5'd3,
        EXC_ECALL_U       = 5'd8,
        EXC_ECALL_M       = 5'd11
    } exception_e;

    // standard mstatus layout with only MIE, MPIE and MPP kept
    typedef struct packed {
        logic [`CSR_XLEN-14:0] pad_hi;
        priv_e                 mpp;
        logic [2:0]            pad_mid;
        logic                  mpie;
        logic [2:0]            pad_lo;
        logic                  mie;
        logic [2:0]            pad_wpri;
    } mstatus_view_t;

    typedef struct packed {
        logic [`CSR_XLEN-3:0] base;
        mtvec_mode_e          mode;
    } mtvec_view_t;

    typedef union packed {
        logic [`CSR_XLEN-1:0] raw;
        mstatus_view_t        status;
        mtvec_view_t          tvec;
    } csr_word_u;

    typedef struct packed {
        logic                   en;
        logic [`CSR_ADDR_W-1:0] id;
        logic                   read;
        logic                   write;
        logic                   mret;
        csr_word_u              wdata;
    } csr_req_t;

    typedef struct packed {
        logic                 valid;
        exception_e           cause;
        logic [`CSR_XLEN-1:0] value;
    } trap_t;

    typedef struct packed {
        logic                 valid;
        logic [`CSR_XLEN-1:0] pc;
    } redirect_t;

    // one bit per kept address
    typedef struct packed {
        logic cycle;
        logic instret;
        logic cycleh;
        logic instreth;
        logic mstatus;
        logic misa;
        logic mtvec;
        logic mcounteren;
        logic mscratch;
        logic mepc;
        logic mcause;
        logic mtval;
        logic mcycle;
        logic minstret;
        logic mcycleh;
        logic minstreth;
    } csr_sel_t;

endpackage

/* hdl/csr_decode.sv */
`timescale 1ns/100ps
`include "csr_defs.svh"

module csr_decode (
    input  csr_pkg::csr_req_t req,
    input  logic              trap_valid,
    input  csr_pkg::priv_e    priv,
    input  logic              mcounteren_cy,
    input  logic              mcounteren_ir,
    output csr_pkg::csr_sel_t sel,
    output logic              write_en,
    output logic              mret_en,
    output logic              illegal
);

    logic m_mode;
    logic user_alias;
    logic known;
    logic read_ok;
    logic write_ok;

    assign sel.cycle      = (req.id == `CSR_ADDR_CYCLE);
    assign sel.instret    = (req.id == `CSR_ADDR_INSTRET);
    assign sel.cycleh     = (req.id == `CSR_ADDR_CYCLEH);
    assign sel.instreth   = (req.id == `CSR_ADDR_INSTRETH);
    assign sel.mstatus    = (req.id == `CSR_ADDR_MSTATUS);
    assign sel.misa       = (req.id == `CSR_ADDR_MISA);
    assign sel.mtvec      = (req.id == `CSR_ADDR_MTVEC);
    assign sel.mcounteren = (req.id == `CSR_ADDR_MCOUNTEREN);
    assign sel.mscratch   = (req.id == `CSR_ADDR_MSCRATCH);
    assign sel.mepc       = (req.id == `CSR_ADDR_MEPC);
    assign sel.mcause     = (req.id == `CSR_ADDR_MCAUSE);
    assign sel.mtval      = (req.id == `CSR_ADDR_MTVAL);
    assign sel.mcycle     = (req.id == `CSR_ADDR_MCYCLE);
    assign sel.minstret   = (req.id == `CSR_ADDR_MINSTRET);
    assign sel.mcycleh    = (req.id == `CSR_ADDR_MCYCLEH);
    assign sel.minstreth  = (req.id == `CSR_ADDR_MINSTRETH);

    assign m_mode     = (priv == csr_pkg::PRIV_M);
    assign user_alias = sel.cycle | sel.cycleh | sel.instret | sel.instreth;
    assign known      = |sel;

    always_comb begin
        if (m_mode) begin
            read_ok  = known;
            // user aliases are read-only
            write_ok = known & ~user_alias;
        end else begin
            read_ok  = ((sel.cycle | sel.cycleh) & mcounteren_cy)
                     | ((sel.instret | sel.instreth) & mcounteren_ir);
            write_ok = 1'b0;
        end
    end

    assign illegal = req.en & ((req.read & ~read_ok)
                             | (req.write & ~write_ok)
                             | (req.mret & ~m_mode));

    assign write_en = req.en & req.write & ~trap_valid & ~illegal;
    assign mret_en  = req.en & req.mret & m_mode;

endmodule

/* hdl/csr_machine_state.sv */
`timescale 1ns/100ps
`include "csr_defs.svh"

module csr_machine_state (
    input  logic                 clk,
    input  logic                 rst_n,
    input  csr_pkg::csr_req_t    req,
    input  csr_pkg::csr_sel_t    sel,
    input  logic                 write_en,
    input  logic                 mret_en,
    input  csr_pkg::trap_t       trap,
    input  logic [`CSR_XLEN-1:0] pc,
    output csr_pkg::priv_e       priv,
    output csr_pkg::csr_word_u   mstatus,
    output csr_pkg::csr_word_u   mtvec,
    output logic [`CSR_XLEN-1:0] mscratch,
    output logic [`CSR_XLEN-1:0] mepc,
    output logic [`CSR_XLEN-1:0] mcause,
    output logic [`CSR_XLEN-1:0] mtval,
    output csr_pkg::redirect_t   redirect
);

    logic                 mie;
    logic                 mpie;
    csr_pkg::priv_e       mpp;
    logic [`CSR_XLEN-3:0] mtvec_base;
    csr_pkg::mtvec_mode_e mtvec_mode;
    logic [`CSR_XLEN-3:0] mepc_base;
    logic                 mpp_legal;
    logic                 mode_legal;

    // write any, read legal
    assign mpp_legal  = (req.wdata.status.mpp == csr_pkg::PRIV_M)
                     || (req.wdata.status.mpp == csr_pkg::PRIV_U);
    assign mode_legal = (req.wdata.tvec.mode == csr_pkg::MTVEC_DIRECT)
                     || (req.wdata.tvec.mode == csr_pkg::MTVEC_VECTORED);

    // privilege and mstatus stack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            priv <= csr_pkg::PRIV_M;
            mie  <= 1'b0;
            mpie <= 1'b1;
            mpp  <= csr_pkg::PRIV_U;
        end else if (trap.valid) begin
            priv <= csr_pkg::PRIV_M;
            mie  <= 1'b0;
            mpie <= mie;
            mpp  <= priv;
        end else if (mret_en) begin
            priv <= mpp;
            mie  <= mpie;
            mpie <= 1'b1;
            mpp  <= csr_pkg::PRIV_U;
        end else if (write_en && sel.mstatus) begin
            mie  <= req.wdata.status.mie;
            mpie <= req.wdata.status.mpie;
            if (mpp_legal) begin
                mpp <= req.wdata.status.mpp;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_base <= '0;
            mtvec_mode <= csr_pkg::MTVEC_DIRECT;
        end else if (write_en && sel.mtvec) begin
            mtvec_base <= req.wdata.tvec.base;
            // reserved modes keep the old one
            if (mode_legal) begin
                mtvec_mode <= req.wdata.tvec.mode;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch <= '0;
        end else if (write_en && sel.mscratch) begin
            mscratch <= req.wdata.raw;
        end
    end

    // trap capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc_base <= '0;
            mcause    <= '0;
            mtval     <= '0;
        end else if (trap.valid) begin
            mepc_base <= pc[`CSR_XLEN-1:2];
            mcause    <= `CSR_XLEN'(trap.cause);
            mtval     <= trap.value;
        end else if (write_en) begin
            if (sel.mepc) begin
                mepc_base <= req.wdata.raw[`CSR_XLEN-1:2];
            end
            if (sel.mcause) begin
                mcause <= req.wdata.raw;
            end
            if (sel.mtval) begin
                mtval <= req.wdata.raw;
            end
        end
    end

    always_comb begin
        mstatus             = '0;
        mstatus.status.mie  = mie;
        mstatus.status.mpie = mpie;
        mstatus.status.mpp  = mpp;
        mtvec.tvec.base     = mtvec_base;
        mtvec.tvec.mode     = mtvec_mode;
    end

    assign mepc = {mepc_base, 2'b00};

    // vectored mode also lands on the base
    always_comb begin
        if (trap.valid) begin
            redirect.valid = 1'b1;
            redirect.pc    = {mtvec_base, 2'b00};
        end else if (mret_en) begin
            redirect.valid = 1'b1;
            redirect.pc    = mepc;
        end else begin
            redirect.valid = 1'b0;
            redirect.pc    = '0;
        end
    end

endmodule

/* hdl/csr_counters.sv */
`timescale 1ns/100ps
`include "csr_defs.svh"

module csr_counters (
    input  logic                   clk,
    input  logic                   rst_n,
    input  csr_pkg::csr_req_t      req,
    input  csr_pkg::csr_sel_t      sel,
    input  logic                   write_en,
    input  logic                   trap_valid,
    input  logic                   instr_done,
    output logic [2*`CSR_XLEN-1:0] mcycle,
    output logic [2*`CSR_XLEN-1:0] minstret,
    output logic                   mcounteren_cy,
    output logic                   mcounteren_ir
);

    logic [2*`CSR_XLEN-1:0] mcycle_next;
    logic [2*`CSR_XLEN-1:0] minstret_next;
    logic                   retire;

    // no retire in a trap cycle
    assign retire        = instr_done & ~trap_valid;
    assign mcycle_next   = mcycle + 1'b1;
    assign minstret_next = minstret + retire;

    // a half write replaces that half of the incremented value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcycle <= '0;
        end else if (write_en && sel.mcycle) begin
            mcycle <= {mcycle_next[2*`CSR_XLEN-1:`CSR_XLEN], req.wdata.raw};
        end else if (write_en && sel.mcycleh) begin
            mcycle <= {req.wdata.raw, mcycle_next[`CSR_XLEN-1:0]};
        end else begin
            mcycle <= mcycle_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            minstret <= '0;
        end else if (write_en && sel.minstret) begin
            minstret <= {minstret_next[2*`CSR_XLEN-1:`CSR_XLEN], req.wdata.raw};
        end else if (write_en && sel.minstreth) begin
            minstret <= {req.wdata.raw, minstret_next[`CSR_XLEN-1:0]};
        end else begin
            minstret <= minstret_next;
        end
    end

    // CY in bit 0, IR in bit 2
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcounteren_cy <= 1'b0;
            mcounteren_ir <= 1'b0;
        end else if (write_en && sel.mcounteren) begin
            mcounteren_cy <= req.wdata.raw[0];
            mcounteren_ir <= req.wdata.raw[2];
        end
    end

endmodule

/* hdl/csr_read_mux.sv */
`timescale 1ns/100ps
`include "csr_defs.svh"

module csr_read_mux (
    input  logic [`CSR_ADDR_W-1:0]   id,
    input  csr_pkg::csr_word_u       mstatus,
    input  csr_pkg::csr_word_u       mtvec,
    input  logic [`CSR_XLEN-1:0]     mscratch,
    input  logic [`CSR_XLEN-1:0]     mepc,
    input  logic [`CSR_XLEN-1:0]     mcause,
    input  logic [`CSR_XLEN-1:0]     mtval,
    input  logic [2*`CSR_XLEN-1:0]   mcycle,
    input  logic [2*`CSR_XLEN-1:0]   minstret,
    input  logic                     mcounteren_cy,
    input  logic                     mcounteren_ir,
    output csr_pkg::csr_word_u       rdata
);

    always_comb begin
        case (id)
            // user aliases mirror the machine counters
            `CSR_ADDR_CYCLE,
            `CSR_ADDR_MCYCLE:     rdata.raw = mcycle[`CSR_XLEN-1:0];
            `CSR_ADDR_CYCLEH,
            `CSR_ADDR_MCYCLEH:    rdata.raw = mcycle[2*`CSR_XLEN-1:`CSR_XLEN];
            `CSR_ADDR_INSTRET,
            `CSR_ADDR_MINSTRET:   rdata.raw = minstret[`CSR_XLEN-1:0];
            `CSR_ADDR_INSTRETH,
            `CSR_ADDR_MINSTRETH:  rdata.raw = minstret[2*`CSR_XLEN-1:`CSR_XLEN];
            `CSR_ADDR_MSTATUS:    rdata     = mstatus;
            `CSR_ADDR_MISA:       rdata.raw = `CSR_MISA_VALUE;
            `CSR_ADDR_MTVEC:      rdata     = mtvec;
            `CSR_ADDR_MCOUNTEREN: rdata.raw = {{(`CSR_XLEN-3){1'b0}},
                                               mcounteren_ir, 1'b0, mcounteren_cy};
            `CSR_ADDR_MSCRATCH:   rdata.raw = mscratch;
            `CSR_ADDR_MEPC:       rdata.raw = mepc;
            `CSR_ADDR_MCAUSE:     rdata.raw = mcause;
            `CSR_ADDR_MTVAL:      rdata.raw = mtval;
            default:              rdata.raw = '0;
        endcase
    end

endmodule

/* hdl/csr_top.sv */
`timescale 1ns/100ps
`include "csr_defs.svh"

module csr_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  csr_pkg::csr_req_t    req,
    input  csr_pkg::trap_t       trap,
    input  logic [`CSR_XLEN-1:0] pc,
    input  logic                 instr_done,
    output csr_pkg::csr_word_u   rdata,
    output csr_pkg::redirect_t   redirect,
    output csr_pkg::priv_e       priv,
    output logic                 illegal
);

    csr_pkg::csr_sel_t      sel;
    logic                   write_en;
    logic                   mret_en;
    csr_pkg::csr_word_u     mstatus;
    csr_pkg::csr_word_u     mtvec;
    logic [`CSR_XLEN-1:0]   mscratch;
    logic [`CSR_XLEN-1:0]   mepc;
    logic [`CSR_XLEN-1:0]   mcause;
    logic [`CSR_XLEN-1:0]   mtval;
    logic [2*`CSR_XLEN-1:0] mcycle;
    logic [2*`CSR_XLEN-1:0] minstret;
    logic                   mcounteren_cy;
    logic                   mcounteren_ir;

    csr_decode decode_i (
        .req           (req),
        .trap_valid    (trap.valid),
        .priv          (priv),
        .mcounteren_cy (mcounteren_cy),
        .mcounteren_ir (mcounteren_ir),
        .sel           (sel),
        .write_en      (write_en),
        .mret_en       (mret_en),
        .illegal       (illegal)
    );

    csr_machine_state machine_state_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .sel      (sel),
        .write_en (write_en),
        .mret_en  (mret_en),
        .trap     (trap),
        .pc       (pc),
        .priv     (priv),
        .mstatus  (mstatus),
        .mtvec    (mtvec),
        .mscratch (mscratch),
        .mepc     (mepc),
        .mcause   (mcause),
        .mtval    (mtval),
        .redirect (redirect)
    );

    csr_counters counters_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .sel           (sel),
        .write_en      (write_en),
        .trap_valid    (trap.valid),
        .instr_done    (instr_done),
        .mcycle        (mcycle),
        .minstret      (minstret),
        .mcounteren_cy (mcounteren_cy),
        .mcounteren_ir (mcounteren_ir)
    );

    csr_read_mux read_mux_i (
        .id            (req.id),
        .mstatus       (mstatus),
        .mtvec         (mtvec),
        .mscratch      (mscratch),
        .mepc          (mepc),
        .mcause        (mcause),
        .mtval         (mtval),
        .mcycle        (mcycle),
        .minstret      (minstret),
        .mcounteren_cy (mcounteren_cy),
        .mcounteren_ir (mcounteren_ir),
        .rdata         (rdata)
    );

endmodule

/* sim/csr_tb.sv */
`timescale 1ns/100ps
`include "csr_defs.svh"

module csr_tb;

    logic                 clk;
    logic                 rst_n;
    csr_pkg::csr_req_t    req;
    csr_pkg::trap_t       trap;
    logic [`CSR_XLEN-1:0] pc;
    logic                 instr_done;
    csr_pkg::csr_word_u   rdata;
    csr_pkg::redirect_t   redirect;
    csr_pkg::priv_e       priv;
    logic                 illegal;

    // reference model state
    csr_pkg::priv_e ref_priv;
    logic           ref_mie;
    logic           ref_mpie;
    csr_pkg::priv_e ref_mpp;
    logic [29:0]    ref_tvec_base;
    logic [1:0]     ref_tvec_mode;
    logic [31:0]    ref_mscratch;
    logic [31:0]    ref_mepc;
    logic [31:0]    ref_mcause;
    logic [31:0]    ref_mtval;
    logic [63:0]    ref_mcycle;
    logic [63:0]    ref_minstret;
    logic           ref_cy;
    logic           ref_ir;

    // aliases first and machine counters last
    localparam logic [11:0] kept_ids [16] = '{
        `CSR_ADDR_CYCLE, `CSR_ADDR_INSTRET, `CSR_ADDR_CYCLEH, `CSR_ADDR_INSTRETH,
        `CSR_ADDR_MSTATUS, `CSR_ADDR_MISA, `CSR_ADDR_MTVEC, `CSR_ADDR_MCOUNTEREN,
        `CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL,
        `CSR_ADDR_MCYCLE, `CSR_ADDR_MINSTRET, `CSR_ADDR_MCYCLEH, `CSR_ADDR_MINSTRETH
    };

    csr_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .trap       (trap),
        .pc         (pc),
        .instr_done (instr_done),
        .rdata      (rdata),
        .redirect   (redirect),
        .priv       (priv),
        .illegal    (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_word(input string name, input csr_pkg::csr_word_u exp,
                              input csr_pkg::csr_word_u act);
        if (act.raw !== exp.raw) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp.raw, act.raw);
            $display("TESTBENCH FAILED");
            $fatal(1, "data word mismatch in %s", name);
        end
    endtask

    task automatic check_redirect(input string name, input csr_pkg::redirect_t exp,
                                  input csr_pkg::redirect_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "redirect mismatch in %s", name);
        end
    endtask

    task automatic check_priv(input string name, input csr_pkg::priv_e exp,
                              input csr_pkg::priv_e act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "privilege mismatch in %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "flag mismatch in %s", name);
        end
    endtask

    function automatic logic is_kept(input logic [11:0] id);
        for (int k = 0; k < 16; k++) begin
            if (kept_ids[k] == id) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic logic is_alias(input logic [11:0] id);
        return (id == `CSR_ADDR_CYCLE) || (id == `CSR_ADDR_CYCLEH)
            || (id == `CSR_ADDR_INSTRET) || (id == `CSR_ADDR_INSTRETH);
    endfunction

    function automatic csr_pkg::csr_word_u ref_read(input logic [11:0] id);
        csr_pkg::csr_word_u w;
        w.raw = '0;
        case (id)
            `CSR_ADDR_CYCLE, `CSR_ADDR_MCYCLE:       w.raw = ref_mcycle[31:0];
            `CSR_ADDR_CYCLEH, `CSR_ADDR_MCYCLEH:     w.raw = ref_mcycle[63:32];
            `CSR_ADDR_INSTRET, `CSR_ADDR_MINSTRET:   w.raw = ref_minstret[31:0];
            `CSR_ADDR_INSTRETH, `CSR_ADDR_MINSTRETH: w.raw = ref_minstret[63:32];
            `CSR_ADDR_MSTATUS: begin
                w.raw[3]     = ref_mie;
                w.raw[7]     = ref_mpie;
                w.raw[12:11] = ref_mpp;
            end
            `CSR_ADDR_MISA:       w.raw = `CSR_MISA_VALUE;
            `CSR_ADDR_MTVEC:      w.raw = {ref_tvec_base, ref_tvec_mode};
            `CSR_ADDR_MCOUNTEREN: w.raw = {29'd0, ref_ir, 1'b0, ref_cy};
            `CSR_ADDR_MSCRATCH:   w.raw = ref_mscratch;
            `CSR_ADDR_MEPC:       w.raw = ref_mepc;
            `CSR_ADDR_MCAUSE:     w.raw = ref_mcause;
            `CSR_ADDR_MTVAL:      w.raw = ref_mtval;
            default: ;
        endcase
        return w;
    endfunction

    function automatic csr_pkg::csr_req_t make_req(input logic en, input logic [11:0] id,
                                                   input logic rd, input logic wr,
                                                   input logic mr, input logic [31:0] wdata);
        csr_pkg::csr_req_t r;
        r.en        = en;
        r.id        = id;
        r.read      = rd;
        r.write     = wr;
        r.mret      = mr;
        r.wdata.raw = wdata;
        return r;
    endfunction

    function automatic csr_pkg::trap_t random_trap();
        csr_pkg::trap_t t;
        t.valid = 1'b1;
        case ($urandom % 4)
            0:       t.cause = csr_pkg::EXC_ILLEGAL_INSTR;
            1:       t.cause = csr_pkg::EXC_BREAKPOINT;
            2:       t.cause = csr_pkg::EXC_ECALL_U;
            default: t.cause = csr_pkg::EXC_ECALL_M;
        endcase
        t.value = $urandom;
        return t;
    endfunction

    // mostly kept addresses and now and then any address
    function automatic logic [11:0] random_id();
        logic [31:0] r;
        r = $urandom;
        if (r[2:0] == 3'd0) begin
            return r[15:4];
        end
        return kept_ids[r[7:4]];
    endfunction

    task automatic reset_model();
        ref_priv      = csr_pkg::PRIV_M;
        ref_mie       = 1'b0;
        ref_mpie      = 1'b1;
        ref_mpp       = csr_pkg::PRIV_U;
        ref_tvec_base = '0;
        ref_tvec_mode = '0;
        ref_mscratch  = '0;
        ref_mepc      = '0;
        ref_mcause    = '0;
        ref_mtval     = '0;
        ref_mcycle    = '0;
        ref_minstret  = '0;
        ref_cy        = 1'b0;
        ref_ir        = 1'b0;
    endtask

    task automatic advance_model(input csr_pkg::csr_req_t r, input csr_pkg::trap_t t,
                                 input logic done, input logic wen, input logic mret_ok);
        logic [63:0] cyc_next;
        logic [63:0] ins_next;
        cyc_next = ref_mcycle + 64'd1;
        ins_next = ref_minstret + ((done && !t.valid) ? 64'd1 : 64'd0);
        if (t.valid) begin
            ref_mpp    = ref_priv;
            ref_priv   = csr_pkg::PRIV_M;
            ref_mpie   = ref_mie;
            ref_mie    = 1'b0;
            ref_mepc   = {pc[31:2], 2'b00};
            ref_mcause = {27'd0, t.cause};
            ref_mtval  = t.value;
        end else if (mret_ok) begin
            ref_priv = ref_mpp;
            ref_mie  = ref_mpie;
            ref_mpie = 1'b1;
            ref_mpp  = csr_pkg::PRIV_U;
        end
        if (wen) begin
            case (r.id)
                `CSR_ADDR_MSTATUS: begin
                    if (!mret_ok) begin
                        ref_mie  = r.wdata.raw[3];
                        ref_mpie = r.wdata.raw[7];
                        // only M or U are legal MPP values
                        if (r.wdata.raw[12:11] == 2'd3 || r.wdata.raw[12:11] == 2'd0) begin
                            ref_mpp = csr_pkg::priv_e'(r.wdata.raw[12:11]);
                        end
                    end
                end
                `CSR_ADDR_MTVEC: begin
                    ref_tvec_base = r.wdata.raw[31:2];
                    if (r.wdata.raw[1:0] < 2'd2) begin
                        ref_tvec_mode = r.wdata.raw[1:0];
                    end
                end
                `CSR_ADDR_MCOUNTEREN: begin
                    ref_cy = r.wdata.raw[0];
                    ref_ir = r.wdata.raw[2];
                end
                `CSR_ADDR_MSCRATCH:  ref_mscratch = r.wdata.raw;
                `CSR_ADDR_MEPC:      ref_mepc = {r.wdata.raw[31:2], 2'b00};
                `CSR_ADDR_MCAUSE:    ref_mcause = r.wdata.raw;
                `CSR_ADDR_MTVAL:     ref_mtval = r.wdata.raw;
                `CSR_ADDR_MCYCLE:    cyc_next[31:0] = r.wdata.raw;
                `CSR_ADDR_MCYCLEH:   cyc_next[63:32] = r.wdata.raw;
                `CSR_ADDR_MINSTRET:  ins_next[31:0] = r.wdata.raw;
                `CSR_ADDR_MINSTRETH: ins_next[63:32] = r.wdata.raw;
                default: ;
            endcase
        end
        ref_mcycle   = cyc_next;
        ref_minstret = ins_next;
    endtask

    // called at a falling edge and returns at the next one
    task automatic run_cycle(input string name, input csr_pkg::csr_req_t r,
                             input csr_pkg::trap_t t, input logic done);
        csr_pkg::csr_word_u exp_rdata;
        csr_pkg::redirect_t exp_redirect;
        logic               m_mode;
        logic               read_ok;
        logic               write_ok;
        logic               exp_illegal;
        logic               wen;
        logic               mret_ok;
        req        = r;
        trap       = t;
        pc         = $urandom;
        instr_done = done;
        #8;
        m_mode = (ref_priv == csr_pkg::PRIV_M);
        if (m_mode) begin
            read_ok  = is_kept(r.id);
            write_ok = is_kept(r.id) && !is_alias(r.id);
        end else begin
            read_ok  = ((r.id == `CSR_ADDR_CYCLE || r.id == `CSR_ADDR_CYCLEH) && ref_cy)
                    || ((r.id == `CSR_ADDR_INSTRET || r.id == `CSR_ADDR_INSTRETH) && ref_ir);
            write_ok = 1'b0;
        end
        exp_illegal = r.en && ((r.read && !read_ok) || (r.write && !write_ok)
                               || (r.mret && !m_mode));
        wen          = r.en && r.write && !t.valid && !exp_illegal;
        mret_ok      = r.en && r.mret && m_mode;
        exp_rdata    = ref_read(r.id);
        exp_redirect = '0;
        if (t.valid) begin
            exp_redirect.valid = 1'b1;
            exp_redirect.pc    = {ref_tvec_base, 2'b00};
        end else if (mret_ok) begin
            exp_redirect.valid = 1'b1;
            exp_redirect.pc    = ref_mepc;
        end
        check_word({name, " rdata"}, exp_rdata, rdata);
        check_bit({name, " illegal"}, exp_illegal, illegal);
        check_redirect({name, " redirect"}, exp_redirect, redirect);
        check_priv({name, " priv"}, ref_priv, priv);
        advance_model(r, t, done, wen, mret_ok);
        @(negedge clk);
    endtask

    task automatic enter_user_mode();
        int waited;
        waited = 0;
        run_cycle("user_mpp", make_req(1'b1, `CSR_ADDR_MSTATUS, 1'b0, 1'b1, 1'b0, 32'h0),
                  '0, 1'b0);
        run_cycle("user_mret", make_req(1'b1, 12'h0, 1'b0, 1'b0, 1'b1, 32'h0), '0, 1'b0);
        while (priv !== csr_pkg::PRIV_U) begin
            if (waited >= 8) begin
                $display("timeout: priv did not switch to U mode after mret");
                $display("TESTBENCH FAILED");
                $fatal(1, "timeout waiting for U mode");
            end
            run_cycle("user_wait", '0, '0, 1'b0);
            waited++;
        end
    endtask

    initial begin
        csr_pkg::csr_word_u expect_word;
        logic [11:0]        id;
        logic [31:0]        wdata;
        int                 op;
        void'($urandom(43));
        rst_n      = 1'b0;
        req        = '0;
        trap       = '0;
        pc         = '0;
        instr_done = 1'b0;
        reset_model();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // reset values
        run_cycle("reset_mstatus", make_req(1'b1, `CSR_ADDR_MSTATUS, 1'b1, 1'b0, 1'b0, 32'h0),
                  '0, 1'b0);
        expect_word.raw = 32'h0000_0080;
        check_word("reset_mstatus_value", expect_word, rdata);
        check_priv("reset_priv", csr_pkg::PRIV_M, priv);
        check_bit("reset_redirect_valid", 1'b0, redirect.valid);
        run_cycle("reset_misa", make_req(1'b1, `CSR_ADDR_MISA, 1'b1, 1'b0, 1'b0, 32'h0),
                  '0, 1'b0);
        expect_word.raw = `CSR_MISA_VALUE;
        check_word("reset_misa_value", expect_word, rdata);

        // machine mode write and read back
        for (int i = 0; i < 300; i++) begin
            id    = kept_ids[4 + ($urandom % 12)];
            wdata = $urandom;
            run_cycle("m_write", make_req(1'b1, id, 1'b0, 1'b1, 1'b0, wdata), '0,
                      ($urandom % 2 == 0));
            run_cycle("m_read", make_req(1'b1, id, 1'b1, 1'b0, 1'b0, 32'h0), '0,
                      ($urandom % 2 == 0));
        end

        // trap entry, inspection and mret
        for (int i = 0; i < 60; i++) begin
            run_cycle("trap_mtvec", make_req(1'b1, `CSR_ADDR_MTVEC, 1'b0, 1'b1, 1'b0, $urandom),
                      '0, 1'b0);
            run_cycle("trap_entry", '0, random_trap(), 1'b1);
            run_cycle("trap_mepc", make_req(1'b1, `CSR_ADDR_MEPC, 1'b1, 1'b0, 1'b0, 32'h0),
                      '0, 1'b0);
            run_cycle("trap_mcause", make_req(1'b1, `CSR_ADDR_MCAUSE, 1'b1, 1'b0, 1'b0, 32'h0),
                      '0, 1'b0);
            run_cycle("trap_mtval", make_req(1'b1, `CSR_ADDR_MTVAL, 1'b1, 1'b0, 1'b0, 32'h0),
                      '0, 1'b0);
            run_cycle("trap_mstatus", make_req(1'b1, `CSR_ADDR_MSTATUS, 1'b1, 1'b0, 1'b0, 32'h0),
                      '0, 1'b0);
            run_cycle("trap_set_mpp", make_req(1'b1, `CSR_ADDR_MSTATUS, 1'b0, 1'b1, 1'b0,
                      $urandom), '0, 1'b0);
            run_cycle("trap_mret", make_req(1'b1, 12'h0, 1'b0, 1'b0, 1'b1, 32'h0), '0, 1'b0);
            if (ref_priv == csr_pkg::PRIV_U) begin
                run_cycle("trap_back", '0, random_trap(), 1'b0);
            end
        end

        // counters with half writes and retire pulses
        for (int i = 0; i < 400; i++) begin
            op = $urandom % 8;
            id = (op < 4) ? kept_ids[op] : kept_ids[8 + op];
            run_cycle("counters", make_req(1'b1, id, 1'b1, ($urandom % 4 == 0), 1'b0, $urandom),
                      ($urandom % 8 == 0) ? random_trap() : '0, ($urandom % 2 == 0));
        end

        // user mode with each mcounteren setting
        for (int round = 0; round < 4; round++) begin
            wdata = {29'd0, round[1], 1'b0, round[0]};
            run_cycle("user_counteren", make_req(1'b1, `CSR_ADDR_MCOUNTEREN, 1'b0, 1'b1, 1'b0,
                      wdata), '0, 1'b0);
            enter_user_mode();
            for (int i = 0; i < 80; i++) begin
                run_cycle("user_access", make_req(1'b1, random_id(), ($urandom % 2 == 0),
                          ($urandom % 2 == 0), ($urandom % 4 == 0), $urandom), '0,
                          ($urandom % 2 == 0));
            end
            run_cycle("user_trap", '0, random_trap(), 1'b0);
        end

        // mixed traffic, op 7 writes and returns in the same request
        for (int i = 0; i < 5000; i++) begin
            op = $urandom % 8;
            run_cycle("mixed", make_req(($urandom % 8 != 0), random_id(), ($urandom % 2 == 0),
                      (op < 3 || op == 7), (op >= 6), $urandom),
                      ($urandom % 16 == 0) ? random_trap() : '0, ($urandom % 2 == 0));
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_decode.sv
hdl/csr_machine_state.sv
hdl/csr_counters.sv
hdl/csr_read_mux.sv
hdl/csr_top.sv
sim/csr_tb.sv

/* Makefile */
SRCS := $(shell grep -v '^+' flist.f)

.PHONY: all run clean

all: run

obj_dir/Vcsr_tb: flist.f hdl/csr_defs.svh $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module csr_tb -f flist.f -o Vcsr_tb

run: obj_dir/Vcsr_tb
	./obj_dir/Vcsr_tb

clean:
	rm -rf obj_dir
